/* filelist.f */
hw/hdmi_cap_pkg.sv
hw/raster_counter.sv
hw/pixel_capture.sv
hw/pixel_bank.sv
hw/gmii_serializer.sv
hw/hdmi_cap_top.sv
verification/tb_hdmi_cap.sv

/* verification/tb_hdmi_cap.sv */
module tb_hdmi_cap;
	timeunit 1ns;
	timeprecision 1ps;
	import hdmi_cap_pkg::*;

	localparam int LINE_LEN = 1500; // Columns per line
	localparam int IDLE_RUN = 64;   // Quiet cycles that end a segment
	localparam int WAIT_MAX = 20000;

	logic             rx0_pclk;
	logic             RSTBTN;
	video_in_t        vid;
	gmii_t            gmii;
	logic [CNT_W-1:0] drop_count;

	logic [31:0]      rnd_state;
	logic [CNT_W-1:0] m_hcnt;    // Model raster position
	logic [CNT_W-1:0] m_vcnt;
	logic             m_hs_prev;
	logic             m_vs_prev;
	send_word_t       exp_q [$]; // Window pixels in capture order
	int               line_no;
	int               total_win;
	int               received;
	logic [$bits(send_word_t)-1:0] shift;
	int               nbytes;
	bit               resetting;
	bit               idle_check;
	int               errors;
	int               ntests;
	int               nfailed;

	hdmi_cap_top i_dut (
		.rx0_pclk   (rx0_pclk),
		.RSTBTN     (RSTBTN),
		.vid        (vid),
		.gmii       (gmii),
		.drop_count (drop_count)
	);

	initial rx0_pclk = 1'b0;
	always #2 rx0_pclk = ~rx0_pclk;

	function automatic logic [31:0] xorshift();
		logic [31:0] x;
		x = rnd_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rnd_state = x;
		return x;
	endfunction

	function automatic string word_text(input send_word_t w);
		return $sformatf("line %h index %h rgb %h_%h_%h", w.line, w.index,
			w.red, w.green, w.blue);
	endfunction

	//////////////////////////////
	// Checks
	//////////////////////////////
	task automatic check_word(input send_word_t got, input send_word_t exp);
		if (got !== exp) begin
			$display("mismatch word: got %s exp %s", word_text(got), word_text(exp));
			errors++;
		end
	endtask

	task automatic check_count(input string name, input logic [CNT_W-1:0] got,
		input logic [CNT_W-1:0] exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h exp %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h exp %h", name, got, exp);
			errors++;
		end
	endtask

	//////////////////////////////
	// Model and stimulus
	//////////////////////////////
	function automatic void model_step(input video_in_t v);
		send_word_t w;
		if (v.vsync && !m_vs_prev) begin
			m_vcnt = '0;
		end else if (v.hsync && !m_hs_prev) begin
			m_vcnt = m_vcnt + 1'b1;
		end
		m_hcnt = (v.hsync && !m_hs_prev) ? '0 : m_hcnt + 1'b1;
		m_hs_prev = v.hsync;
		m_vs_prev = v.vsync;
		if (v.vde && m_hcnt >= WIN_FIRST && m_hcnt <= WIN_LAST) begin
			w = '{line: m_vcnt, index: m_hcnt - WIN_FIRST,
				red: v.red, green: v.green, blue: v.blue};
			exp_q.push_back(w);
			total_win++;
		end
	endfunction

	task automatic drive_cycle(input video_in_t v);
		@(negedge rx0_pclk);
		// Quiet only until the first window pixel
		if (idle_check && total_win == 0) begin
			check_flag("gmii.tx_en", gmii.tx_en, 1'b0);
			check_count("drop_count", drop_count, '0);
		end
		RSTBTN = 1'b0;
		vid    = v;
		model_step(v);
	endtask

	// Mode 0 blank, 1 active, 2 random per line
	task automatic drive_line(input int mode, input int cols);
		logic [31:0] r;
		int          j;
		bit          act;
		video_in_t   v;
		r   = xorshift();
		j   = r[1:0];   // hsync jitter
		act = (mode == 1) || (mode == 2 && r[3:2] != 2'b00);
		for (int p = 0; p < cols; p++) begin
			r       = xorshift();
			v.hsync = (p >= j) && (p < j + 10);
			v.vsync = v.hsync && (line_no % 3 == 0); // New frame every third line
			v.vde   = act && (p >= j + 160) && (p < j + 1480);
			v.red   = r[7:0];
			v.green = r[15:8];
			v.blue  = r[23:16];
			drive_cycle(v);
		end
		line_no++;
	endtask

	task automatic apply_reset();
		@(posedge rx0_pclk);
		resetting = 1'b1;
		@(negedge rx0_pclk);
		RSTBTN = 1'b1;
		vid    = '0;
		repeat (4) @(negedge rx0_pclk);
		check_flag("gmii.tx_en", gmii.tx_en, 1'b0);
		check_count("drop_count", drop_count, '0);
		exp_q.delete(); // Words in flight are lost
		{m_hcnt, m_vcnt, m_hs_prev, m_vs_prev} = '0;
		{line_no, total_win, received} = '0;
		resetting = 1'b0;
	endtask

	task automatic wait_idle();
		int quiet;
		int n;
		quiet = 0;
		n     = 0;
		while (quiet < IDLE_RUN && n < WAIT_MAX) begin
			drive_cycle('0);
			quiet = gmii.tx_en ? 0 : quiet + 1;
			n++;
		end
		if (quiet < IDLE_RUN) begin
			$display("timeout: GMII stream never went idle");
			errors++;
		end
	endtask

	// Every window pixel either left as a word or was counted as dropped
	task automatic check_totals();
		check_count("drop_count", drop_count, CNT_W'(total_win - received));
	endtask

	task automatic match_received(input send_word_t got);
		if (exp_q.size() == 0) begin
			$display("received word %s with no captured pixel left", word_text(got));
			errors++;
		end else begin
			// Older entries without a match were dropped at capture
			while (exp_q.size() > 1 &&
				(exp_q[0].line !== got.line || exp_q[0].index !== got.index)) begin
				exp_q.delete(0);
			end
			check_word(got, exp_q.pop_front());
			received++;
		end
	endtask

	task automatic report_test(input string name, input int mark);
		ntests++;
		if (errors == mark) begin
			$display("test %s: ok", name);
		end else begin
			nfailed++;
			$display("test %s: %0d errors", name, errors - mark);
		end
	endtask

	//////////////////////////////
	// GMII monitor
	//////////////////////////////
	always @(negedge rx0_pclk) begin
		if (gmii.tx_en === 1'b1) begin
			shift = {shift[$bits(send_word_t)-9:0], gmii.txd}; // MSB first
			nbytes++;
			if (nbytes == BYTES_PER_WORD) begin
				match_received(shift);
				nbytes = 0;
			end
		end else begin
			if (nbytes != 0 && !resetting) begin
				$display("tx_en dropped after %0d bytes of a word", nbytes);
				errors++;
			end
			nbytes = 0;
		end
	end

	initial begin
		int mark;
		RSTBTN     = 1'b1;
		vid        = '0;
		rnd_state  = 32'h2c46_2ab0;
		{errors, ntests, nfailed, nbytes} = '0;
		{resetting, idle_check} = '0;
		shift      = '0;

		mark = errors;
		apply_reset();
		idle_check = 1'b1;
		drive_line(1, LINE_LEN); // Nothing may leave before the window opens
		idle_check = 1'b0;
		report_test("reset_idle", mark);

		mark = errors;
		repeat (3) drive_line(2, LINE_LEN);
		wait_idle();
		check_totals();
		report_test("random_frames", mark);

		mark = errors;
		drive_line(1, 900); // Cut off in the middle of the window
		apply_reset();
		report_test("mid_frame_reset", mark);

		mark = errors;
		idle_check = 1'b1;
		drive_line(1, LINE_LEN);
		idle_check = 1'b0;
		repeat (3) drive_line(2, LINE_LEN);
		wait_idle();
		check_totals();
		report_test("frames_after_reset", mark);

		$display("tests %0d, failed %0d, errors %0d", ntests, nfailed, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* hw/hdmi_cap_top.sv */
module hdmi_cap_top (
	input  logic                           rx0_pclk,
	input  logic                           RSTBTN,
	input  hdmi_cap_pkg::video_in_t        vid,
	output hdmi_cap_pkg::gmii_t            gmii,
	output logic [hdmi_cap_pkg::CNT_W-1:0] drop_count
);
	import hdmi_cap_pkg::*;

	raster_t              pos;
	video_in_t            pix;        // Video delayed to match pos
	logic [NUM_BANKS-1:0] wr;
	send_word_t           word;
	logic [NUM_BANKS-1:0] pop;        // Pop doubles as credit return
	logic [NUM_BANKS-1:0] not_empty;
	send_word_t           heads [NUM_BANKS];

	raster_counter i_raster (
		.rx0_pclk (rx0_pclk),
		.RSTBTN   (RSTBTN),
		.vid      (vid),
		.pos      (pos),
		.pix      (pix)
	);

	pixel_capture i_capture (
		.rx0_pclk      (rx0_pclk),
		.RSTBTN        (RSTBTN),
		.pos           (pos),
		.pix           (pix),
		.wr            (wr),
		.word          (word),
		.credit_return (pop),
		.drop_count    (drop_count)
	);

	//////////////////////////////
	// Pixel banks
	//////////////////////////////
	for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
		pixel_bank i_bank (
			.rx0_pclk  (rx0_pclk),
			.RSTBTN    (RSTBTN),
			.wr        (wr[g]),
			.word_in   (word), // Shared bus, wr picks the bank
			.pop       (pop[g]),
			.head      (heads[g]),
			.not_empty (not_empty[g])
		);
	end

	gmii_serializer i_serializer (
		.rx0_pclk  (rx0_pclk),
		.RSTBTN    (RSTBTN),
		.heads     (heads),
		.not_empty (not_empty),
		.pop       (pop),
		.gmii      (gmii)
	);

endmodule

/* hw/gmii_serializer.sv */
module gmii_serializer (
	input  logic                               rx0_pclk,
	input  logic                               RSTBTN,
	input  hdmi_cap_pkg::send_word_t           heads [hdmi_cap_pkg::NUM_BANKS],
	input  logic [hdmi_cap_pkg::NUM_BANKS-1:0] not_empty,
	output logic [hdmi_cap_pkg::NUM_BANKS-1:0] pop,
	output hdmi_cap_pkg::gmii_t                gmii
);
	import hdmi_cap_pkg::*;

	ser_state_e                    state;
	logic [BANK_IDX_W-1:0]         rd_ptr;
	logic [BYTE_CNT_W-1:0]         byte_cnt;
	logic [$bits(send_word_t)-1:0] shreg;
	logic                          last_byte;
	logic                          take;

	assign last_byte = (byte_cnt == BYTE_CNT_W'(BYTES_PER_WORD - 1));

	// Next word is taken when idle or on the last byte of the current one
	assign take = not_empty[rd_ptr] &
		((state == SER_IDLE) | ((state == SER_SEND) & last_byte));

	// Also the credit return to the capture side
	always_comb begin
		pop         = '0;
		pop[rd_ptr] = take;
	end

	//////////////////////////////
	// Byte FSM
	//////////////////////////////
	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN) begin
			state    <= SER_IDLE;
			rd_ptr   <= '0;
			byte_cnt <= '0;
			gmii     <= '0;
		end else begin
			case (state)
				SER_IDLE: begin
					gmii <= '0;
					if (take) begin
						state    <= SER_SEND;
						byte_cnt <= '0;
					end
				end
				SER_SEND: begin
					gmii.tx_en <= 1'b1;
					gmii.txd   <= shreg[$bits(send_word_t)-1 -: 8]; // MSB first
					if (last_byte) begin
						byte_cnt <= '0;
						if (!take) begin
							state <= SER_IDLE;
						end
					end else begin
						byte_cnt <= byte_cnt + BYTE_CNT_W'(1);
					end
				end
				default: state <= SER_IDLE;
			endcase

			if (take) begin
				rd_ptr <= rd_ptr + BANK_IDX_W'(1); // Same order as the writes
			end
		end
	end

	// Word latch and shifter
	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN) begin
			shreg <= '0;
		end else if (take) begin
			shreg <= heads[rd_ptr];
		end else if (state == SER_SEND) begin
			shreg <= {shreg[$bits(send_word_t)-9:0], 8'h00};
		end
	end

endmodule

/* hw/pixel_bank.sv */
module pixel_bank (
	input  logic                     rx0_pclk,
	input  logic                     RSTBTN,
	input  logic                     wr,
	input  hdmi_cap_pkg::send_word_t word_in,
	input  logic                     pop,
	output hdmi_cap_pkg::send_word_t head,
	output logic                     not_empty
);
	import hdmi_cap_pkg::*;

	send_word_t            mem [BANK_DEPTH];
	logic [BANK_PTR_W-1:0] wr_ptr;
	logic [BANK_PTR_W-1:0] rd_ptr;
	logic [BANK_PTR_W:0]   count;

	assign head      = mem[rd_ptr]; // First-word fall-through
	assign not_empty = (count != '0);

	// No full check, the capture credits keep room
	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN) begin
			for (int i = 0; i < BANK_DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (wr) begin
			mem[wr_ptr] <= word_in;
		end
	end

	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr) begin
				wr_ptr <= wr_ptr + BANK_PTR_W'(1);
			end
			if (pop) begin
				rd_ptr <= rd_ptr + BANK_PTR_W'(1);
			end
			case ({wr, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
		end
	end

endmodule

/* hw/pixel_capture.sv */
module pixel_capture (
	input  logic                                 rx0_pclk,
	input  logic                                 RSTBTN,
	input  hdmi_cap_pkg::raster_t                pos,
	input  hdmi_cap_pkg::video_in_t              pix,
	output logic [hdmi_cap_pkg::NUM_BANKS-1:0]   wr,
	output hdmi_cap_pkg::send_word_t             word,
	input  logic [hdmi_cap_pkg::NUM_BANKS-1:0]   credit_return,
	output logic [hdmi_cap_pkg::CNT_W-1:0]       drop_count
);
	import hdmi_cap_pkg::*;

	logic [CREDIT_W-1:0]   credit [NUM_BANKS]; // Free slots per bank
	logic [BANK_IDX_W-1:0] wr_ptr;
	logic                  in_win;
	logic                  has_credit;
	logic                  take;
	logic [NUM_BANKS-1:0]  dec;

	//////////////////////////////
	// Window test
	//////////////////////////////
	assign in_win     = pos.active && (pos.hcnt >= WIN_FIRST) && (pos.hcnt <= WIN_LAST);
	assign has_credit = (credit[wr_ptr] != '0);
	assign take       = in_win & has_credit;

	// One-hot of the bank that gets this pixel
	always_comb begin
		dec         = '0;
		dec[wr_ptr] = take;
	end

	//////////////////////////////
	// Credits, pointer and drops
	//////////////////////////////
	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN) begin
			wr         <= '0;
			wr_ptr     <= '0;
			drop_count <= '0;
			for (int i = 0; i < NUM_BANKS; i++) begin
				credit[i] <= CREDIT_W'(BANK_DEPTH);
			end
		end else begin
			wr <= dec; // Write lands one cycle after capture

			// A pop and a capture on the same bank cancel out
			for (int i = 0; i < NUM_BANKS; i++) begin
				credit[i] <= credit[i] - CREDIT_W'(dec[i]) + CREDIT_W'(credit_return[i]);
			end

			if (take) begin
				wr_ptr <= wr_ptr + BANK_IDX_W'(1);
			end

			// Pointer stays put so word order is kept
			if (in_win && !has_credit) begin
				drop_count <= drop_count + CNT_W'(1);
			end
		end
	end

	// Send word follows the write pulse
	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN) begin
			word <= '0;
		end else if (take) begin
			word.line  <= pos.vcnt;
			word.index <= pos.hcnt - WIN_FIRST;
			word.red   <= pix.red;
			word.green <= pix.green;
			word.blue  <= pix.blue;
		end
	end

endmodule

/* hw/raster_counter.sv */
module raster_counter (
	input  logic                    rx0_pclk,
	input  logic                    RSTBTN,
	input  hdmi_cap_pkg::video_in_t vid,
	output hdmi_cap_pkg::raster_t   pos,
	output hdmi_cap_pkg::video_in_t pix
);
	import hdmi_cap_pkg::*;

	logic hs_rise;
	logic vs_rise;

	// pix holds last cycle's input, so it doubles as the edge reference
	assign hs_rise = vid.hsync & ~pix.hsync;
	assign vs_rise = vid.vsync & ~pix.vsync;

	//////////////////////////////
	// Video delay and counters
	//////////////////////////////
	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN) begin
			pix <= '0;
			pos <= '0;
		end else begin
			pix        <= vid;
			pos.active <= vid.vde;

			// Column restarts right after the hsync edge
			if (hs_rise) begin
				pos.hcnt <= '0;
			end else begin
				pos.hcnt <= pos.hcnt + CNT_W'(1);
			end

			if (vs_rise) begin
				pos.vcnt <= '0; // New frame wins over a new line
			end else if (hs_rise) begin
				pos.vcnt <= pos.vcnt + CNT_W'(1);
			end
		end
	end

endmodule

/* hw/hdmi_cap_pkg.sv */
package hdmi_cap_pkg;

	//////////////////////////////
	// Sizes
	//////////////////////////////
	localparam int CNT_W          = 12; // Column and line counters
	localparam int NUM_BANKS      = 4;
	localparam int BANK_DEPTH     = 8;  // Words per bank
	localparam int BANK_IDX_W     = 2;
	localparam int BANK_PTR_W     = $clog2(BANK_DEPTH);
	localparam int CREDIT_W       = 4;  // Holds 0 to BANK_DEPTH
	localparam int BYTES_PER_WORD = 6;
	localparam int BYTE_CNT_W     = $clog2(BYTES_PER_WORD);

	// Capture window, both ends inclusive
	localparam logic [CNT_W-1:0] WIN_FIRST = 12'd221;
	localparam logic [CNT_W-1:0] WIN_LAST  = 12'd1420;

	//////////////////////////////
	// Types
	//////////////////////////////

	// Decoded video from the receiver
	typedef struct packed {
		logic       hsync;
		logic       vsync;
		logic       vde;
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} video_in_t;

	// Recovered raster position
	typedef struct packed {
		logic [CNT_W-1:0] hcnt;
		logic [CNT_W-1:0] vcnt;
		logic             active; // Registered vde
	} raster_t;

	// One captured pixel, sent MSB first
	typedef struct packed {
		logic [CNT_W-1:0] line;
		logic [CNT_W-1:0] index; // Column inside the window
		logic [7:0]       red;
		logic [7:0]       green;
		logic [7:0]       blue;
	} send_word_t;

	// GMII transmit side
	typedef struct packed {
		logic       tx_en;
		logic [7:0] txd;
	} gmii_t;

	typedef enum logic {
		SER_IDLE,
		SER_SEND
	} ser_state_e;

endpackage
